/* rop_params.svh */
`ifndef ROP_PARAMS_SVH
`define ROP_PARAMS_SVH

// Pixel lanes per request.
`define ROP_NUM_LANES 4

// Pixel coordinate width.
`define ROP_DIM_BITS 11

// Depth and stencil field widths, packed together into one 32-bit word.
`define ROP_DEPTH_BITS 24
`define ROP_STENCIL_BITS 8

// Word address is the byte address without bits 1:0.
`define ROP_ADDR_BITS 30

// Request tag width.
`define ROP_TAG_BITS 4

`endif

/* rop_pkg.sv */
package rop_pkg;

    // Memory operation of a whole request.
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    // Memory sequencer states.
    typedef enum logic [2:0] {
        IDLE     = 3'd0,  // Waiting for a request.
        ISSUE    = 3'd1,  // Pick next active slot.
        WAIT_ACK = 3'd2,  // Waiting for mem_ack with mem_req high.
        RELEASE  = 3'd3,  // Waiting for mem_ack to drop.
        RESPOND  = 3'd4   // Response handshake.
    } seq_state_e;

endpackage

/* rop_ds_addr.sv */
`timescale 1ns/1ps
`include "rop_params.svh"

module rop_ds_addr
    import rop_pkg::*;
(
    input  mem_op_e                                          req_op,
    input  logic [`ROP_NUM_LANES-1:0]                        req_lane_mask,
    input  logic [`ROP_NUM_LANES-1:0]                        req_backface,
    input  logic [`ROP_NUM_LANES-1:0][`ROP_DIM_BITS-1:0]     req_pos_x,
    input  logic [`ROP_NUM_LANES-1:0][`ROP_DIM_BITS-1:0]     req_pos_y,
    input  logic [`ROP_NUM_LANES-1:0][`ROP_DEPTH_BITS-1:0]   req_depth,
    input  logic [`ROP_NUM_LANES-1:0][`ROP_STENCIL_BITS-1:0] req_stencil,
    input  logic [31:0]                                      zbuf_addr,
    input  logic [31:0]                                      zbuf_pitch,
    input  logic                                             depth_enable,
    input  logic                                             depth_writemask,
    input  logic                                             stencil_enable,
    input  logic [7:0]                                       stencil_front_writemask,
    input  logic [7:0]                                       stencil_back_writemask,
    output logic [`ROP_NUM_LANES-1:0]                        ds_mask,
    output logic [`ROP_NUM_LANES-1:0][`ROP_ADDR_BITS-1:0]    ds_addr,
    output logic [`ROP_NUM_LANES-1:0][31:0]                  ds_wdata,
    output logic [`ROP_NUM_LANES-1:0][3:0]                   ds_byteen
);

    logic is_read;
    logic depth_on;
    logic stencil_on;

    assign is_read    = (req_op == MEM_READ);
    assign depth_on   = depth_enable && (is_read || depth_writemask);
    assign stencil_on = stencil_enable
                        && (is_read || (stencil_front_writemask != 8'd0)
                                    || (stencil_back_writemask != 8'd0));

    for (genvar i = 0; i < `ROP_NUM_LANES; i++) begin : g_lane
        logic [31:0] byte_addr;
        logic [7:0]  sel_wmask;

        assign byte_addr = zbuf_addr
                           + 32'(req_pos_y[i]) * zbuf_pitch
                           + (32'(req_pos_x[i]) << 2);
        assign sel_wmask = req_backface[i] ? stencil_back_writemask
                                           : stencil_front_writemask;  // Face select.

        assign ds_mask[i]   = req_lane_mask[i] && (depth_on || stencil_on);
        assign ds_addr[i]   = byte_addr[31:2];  // Word aligned.
        assign ds_wdata[i]  = {req_stencil[i], req_depth[i]};
        assign ds_byteen[i] = {(sel_wmask != 8'd0), {3{depth_writemask}}};
    end

endmodule

/* rop_color_addr.sv */
`timescale 1ns/1ps
`include "rop_params.svh"

module rop_color_addr
    import rop_pkg::*;
(
    input  mem_op_e                                       req_op,
    input  logic [`ROP_NUM_LANES-1:0]                     req_lane_mask,
    input  logic [`ROP_NUM_LANES-1:0]                     req_ds_pass,
    input  logic [`ROP_NUM_LANES-1:0][`ROP_DIM_BITS-1:0]  req_pos_x,
    input  logic [`ROP_NUM_LANES-1:0][`ROP_DIM_BITS-1:0]  req_pos_y,
    input  logic [`ROP_NUM_LANES-1:0][31:0]               req_color,
    input  logic [31:0]                                   cbuf_addr,
    input  logic [31:0]                                   cbuf_pitch,
    input  logic [3:0]                                    cbuf_writemask,
    input  logic                                          blend_enable,
    output logic [`ROP_NUM_LANES-1:0]                     color_mask,
    output logic [`ROP_NUM_LANES-1:0][`ROP_ADDR_BITS-1:0] color_addr,
    output logic [`ROP_NUM_LANES-1:0][31:0]               color_wdata,
    output logic [`ROP_NUM_LANES-1:0][3:0]                color_byteen
);

    logic is_read;
    logic color_on;

    assign is_read = (req_op == MEM_READ);

    // Reads only feed the blender and writes need at least one channel.
    assign color_on = is_read ? blend_enable : (cbuf_writemask != 4'd0);

    for (genvar i = 0; i < `ROP_NUM_LANES; i++) begin : g_lane
        logic [31:0] byte_addr;

        assign byte_addr = cbuf_addr
                           + 32'(req_pos_y[i]) * cbuf_pitch
                           + (32'(req_pos_x[i]) << 2);

        assign color_mask[i]   = req_lane_mask[i] && color_on
                                 && (is_read || req_ds_pass[i]);  // Failed lanes skip.
        assign color_addr[i]   = byte_addr[31:2];
        assign color_wdata[i]  = req_color[i];
        assign color_byteen[i] = cbuf_writemask;
    end

endmodule

/* rop_mem_seq.sv */
`timescale 1ns/1ps
`include "rop_params.svh"

module rop_mem_seq
    import rop_pkg::*;
(
    input  logic                                             clk,
    input  logic                                             arst_n,
    input  logic                                             req,
    input  mem_op_e                                          req_op,
    input  logic [`ROP_TAG_BITS-1:0]                         req_tag,
    output logic                                             req_ack,
    input  logic [`ROP_NUM_LANES-1:0]                        ds_mask,
    input  logic [`ROP_NUM_LANES-1:0][`ROP_ADDR_BITS-1:0]    ds_addr,
    input  logic [`ROP_NUM_LANES-1:0][31:0]                  ds_wdata,
    input  logic [`ROP_NUM_LANES-1:0][3:0]                   ds_byteen,
    input  logic [`ROP_NUM_LANES-1:0]                        color_mask,
    input  logic [`ROP_NUM_LANES-1:0][`ROP_ADDR_BITS-1:0]    color_addr,
    input  logic [`ROP_NUM_LANES-1:0][31:0]                  color_wdata,
    input  logic [`ROP_NUM_LANES-1:0][3:0]                   color_byteen,
    output logic                                             mem_req,
    output mem_op_e                                          mem_op,
    output logic [`ROP_ADDR_BITS-1:0]                        mem_addr,
    output logic [31:0]                                      mem_wdata,
    output logic [3:0]                                       mem_byteen,
    input  logic                                             mem_ack,
    input  logic [31:0]                                      mem_rdata,
    output logic                                             rsp_req,
    output logic [`ROP_NUM_LANES-1:0]                        rsp_mask,
    output logic [`ROP_NUM_LANES-1:0][`ROP_DEPTH_BITS-1:0]   rsp_depth,
    output logic [`ROP_NUM_LANES-1:0][`ROP_STENCIL_BITS-1:0] rsp_stencil,
    output logic [`ROP_NUM_LANES-1:0][31:0]                  rsp_color,
    output logic [`ROP_TAG_BITS-1:0]                         rsp_tag,
    input  logic                                             rsp_ack
);

    localparam int NUM_LANES = `ROP_NUM_LANES;
    localparam int NUM_SLOTS = 2 * NUM_LANES;
    localparam int SLOT_W    = $clog2(NUM_SLOTS);

    seq_state_e state;
    logic       req_done;  // Request handshake finished.

    logic [NUM_SLOTS-1:0] pending;
    logic [NUM_LANES-1:0] mask_r;
    logic [SLOT_W-1:0]    cur_slot;
    logic [SLOT_W-1:0]    next_slot;

    mem_op_e                                   op_r;
    logic [`ROP_TAG_BITS-1:0]                  tag_r;
    logic [NUM_SLOTS-1:0][`ROP_ADDR_BITS-1:0]  slot_addr;
    logic [NUM_SLOTS-1:0][31:0]                slot_wdata;
    logic [NUM_SLOTS-1:0][3:0]                 slot_byteen;
    logic [NUM_SLOTS-1:0][31:0]                rdata;

    // Lowest pending slot; depth/stencil lanes sit below colour lanes.
    always_comb begin
        next_slot = '0;
        for (int s = NUM_SLOTS - 1; s >= 0; s--) begin
            if (pending[s]) begin
                next_slot = SLOT_W'(s);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            req_ack  <= 1'b0;
            req_done <= 1'b0;
            mem_req  <= 1'b0;
            rsp_req  <= 1'b0;
            pending  <= '0;
            mask_r   <= '0;
        end else begin
            // Request handshake runs alongside the slot walk.
            if (state != IDLE && !req_done) begin
                if (!req_ack && req) begin
                    req_ack <= 1'b1;
                end else if (req_ack && !req) begin
                    req_ack  <= 1'b0;
                    req_done <= 1'b1;
                end
            end

            case (state)
                IDLE: begin
                    if (req) begin
                        pending  <= {color_mask, ds_mask};
                        mask_r   <= ds_mask | color_mask;
                        req_done <= 1'b0;
                        state    <= ISSUE;
                    end
                end
                ISSUE: begin
                    if (pending != '0) begin
                        mem_req <= 1'b1;
                        state   <= WAIT_ACK;
                    end else if (req_done) begin
                        rsp_req <= 1'b1;  // Empty batch.
                        state   <= RESPOND;
                    end
                end
                WAIT_ACK: begin
                    if (mem_ack) begin
                        mem_req           <= 1'b0;
                        pending[cur_slot] <= 1'b0;
                        state             <= RELEASE;
                    end
                end
                RELEASE: begin
                    if (!mem_ack) begin
                        if (pending == '0 && req_done) begin
                            rsp_req <= 1'b1;
                            state   <= RESPOND;
                        end else begin
                            state <= ISSUE;
                        end
                    end
                end
                RESPOND: begin
                    if (rsp_req && rsp_ack) begin
                        rsp_req <= 1'b0;
                    end else if (!rsp_req && !rsp_ack) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            op_r        <= req_op;
            tag_r       <= req_tag;
            slot_addr   <= {color_addr, ds_addr};
            slot_wdata  <= {color_wdata, ds_wdata};
            slot_byteen <= {color_byteen, ds_byteen};
            rdata       <= '0;  // Unread lanes return zero.
        end
        if (state == ISSUE && pending != '0) begin
            cur_slot   <= next_slot;
            mem_addr   <= slot_addr[next_slot];
            mem_wdata  <= slot_wdata[next_slot];
            mem_byteen <= slot_byteen[next_slot];
        end
        if (state == WAIT_ACK && mem_ack && op_r == MEM_READ) begin
            rdata[cur_slot] <= mem_rdata;
        end
    end

    assign mem_op   = op_r;
    assign rsp_mask = mask_r;
    assign rsp_tag  = tag_r;

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_rsp
        assign rsp_depth[i]   = rdata[i][`ROP_DEPTH_BITS-1:0];
        assign rsp_stencil[i] = rdata[i][31:`ROP_DEPTH_BITS];
        assign rsp_color[i]   = rdata[NUM_LANES + i];
    end

    a_mem_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req && !mem_ack |=> mem_req);

    a_mem_payload_stable: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req && !mem_ack |=> $stable({mem_op, mem_addr, mem_wdata, mem_byteen}));

    a_rsp_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_req && !rsp_ack |=> rsp_req);

endmodule

/* rop_mem.sv */
`timescale 1ns/1ps
`include "rop_params.svh"

module rop_mem
    import rop_pkg::*;
(
    input  logic                                             clk,
    input  logic                                             arst_n,
    input  logic [31:0]                                      zbuf_addr,
    input  logic [31:0]                                      zbuf_pitch,
    input  logic [31:0]                                      cbuf_addr,
    input  logic [31:0]                                      cbuf_pitch,
    input  logic                                             depth_enable,
    input  logic                                             depth_writemask,
    input  logic                                             stencil_enable,
    input  logic                                             blend_enable,
    input  logic [7:0]                                       stencil_front_writemask,
    input  logic [7:0]                                       stencil_back_writemask,
    input  logic [3:0]                                       cbuf_writemask,
    input  logic                                             req,
    output logic                                             req_ack,
    input  mem_op_e                                          req_op,
    input  logic [`ROP_TAG_BITS-1:0]                         req_tag,
    input  logic [`ROP_NUM_LANES-1:0]                        req_lane_mask,
    input  logic [`ROP_NUM_LANES-1:0]                        req_ds_pass,
    input  logic [`ROP_NUM_LANES-1:0]                        req_backface,
    input  logic [`ROP_NUM_LANES-1:0][`ROP_DIM_BITS-1:0]     req_pos_x,
    input  logic [`ROP_NUM_LANES-1:0][`ROP_DIM_BITS-1:0]     req_pos_y,
    input  logic [`ROP_NUM_LANES-1:0][31:0]                  req_color,
    input  logic [`ROP_NUM_LANES-1:0][`ROP_DEPTH_BITS-1:0]   req_depth,
    input  logic [`ROP_NUM_LANES-1:0][`ROP_STENCIL_BITS-1:0] req_stencil,
    output logic                                             mem_req,
    output mem_op_e                                          mem_op,
    output logic [`ROP_ADDR_BITS-1:0]                        mem_addr,
    output logic [31:0]                                      mem_wdata,
    output logic [3:0]                                       mem_byteen,
    input  logic                                             mem_ack,
    input  logic [31:0]                                      mem_rdata,
    output logic                                             rsp_req,
    output logic [`ROP_NUM_LANES-1:0]                        rsp_mask,
    output logic [`ROP_NUM_LANES-1:0][`ROP_DEPTH_BITS-1:0]   rsp_depth,
    output logic [`ROP_NUM_LANES-1:0][`ROP_STENCIL_BITS-1:0] rsp_stencil,
    output logic [`ROP_NUM_LANES-1:0][31:0]                  rsp_color,
    output logic [`ROP_TAG_BITS-1:0]                         rsp_tag,
    input  logic                                             rsp_ack
);

    logic [`ROP_NUM_LANES-1:0]                     ds_mask;
    logic [`ROP_NUM_LANES-1:0][`ROP_ADDR_BITS-1:0] ds_addr;
    logic [`ROP_NUM_LANES-1:0][31:0]               ds_wdata;
    logic [`ROP_NUM_LANES-1:0][3:0]                ds_byteen;
    logic [`ROP_NUM_LANES-1:0]                     color_mask;
    logic [`ROP_NUM_LANES-1:0][`ROP_ADDR_BITS-1:0] color_addr;
    logic [`ROP_NUM_LANES-1:0][31:0]               color_wdata;
    logic [`ROP_NUM_LANES-1:0][3:0]                color_byteen;

    rop_ds_addr ds_addr_i (
        .req_op, .req_lane_mask, .req_backface, .req_pos_x, .req_pos_y,
        .req_depth, .req_stencil, .zbuf_addr, .zbuf_pitch,
        .depth_enable, .depth_writemask, .stencil_enable,
        .stencil_front_writemask, .stencil_back_writemask,
        .ds_mask, .ds_addr, .ds_wdata, .ds_byteen
    );

    rop_color_addr color_addr_i (
        .req_op, .req_lane_mask, .req_ds_pass, .req_pos_x, .req_pos_y,
        .req_color, .cbuf_addr, .cbuf_pitch, .cbuf_writemask, .blend_enable,
        .color_mask, .color_addr, .color_wdata, .color_byteen
    );

    rop_mem_seq seq_i (
        .clk, .arst_n, .req, .req_op, .req_tag, .req_ack,
        .ds_mask, .ds_addr, .ds_wdata, .ds_byteen,
        .color_mask, .color_addr, .color_wdata, .color_byteen,
        .mem_req, .mem_op, .mem_addr, .mem_wdata, .mem_byteen, .mem_ack, .mem_rdata,
        .rsp_req, .rsp_mask, .rsp_depth, .rsp_stencil, .rsp_color, .rsp_tag, .rsp_ack
    );

endmodule

/* rop_mem_checker.sv */
`timescale 1ns/1ps
`include "rop_params.svh"

module rop_mem_checker
    import rop_pkg::*;
(
    input  logic clk, arst_n, req, req_ack, mem_req, rsp_req,
    input  logic depth_enable, depth_writemask, stencil_enable, blend_enable,
    input  logic [31:0] zbuf_addr, zbuf_pitch, cbuf_addr, cbuf_pitch, mem_wdata,
    input  logic [7:0] stencil_front_writemask, stencil_back_writemask,
    input  logic [3:0] cbuf_writemask, mem_byteen,
    input  mem_op_e req_op, mem_op,
    input  logic [`ROP_TAG_BITS-1:0] req_tag, rsp_tag,
    input  logic [`ROP_NUM_LANES-1:0] req_lane_mask, req_ds_pass, req_backface, rsp_mask,
    input  logic [`ROP_NUM_LANES-1:0][`ROP_DIM_BITS-1:0] req_pos_x, req_pos_y,
    input  logic [`ROP_NUM_LANES-1:0][31:0] req_color, rsp_color,
    input  logic [`ROP_NUM_LANES-1:0][`ROP_DEPTH_BITS-1:0] req_depth, rsp_depth,
    input  logic [`ROP_NUM_LANES-1:0][`ROP_STENCIL_BITS-1:0] req_stencil, rsp_stencil,
    input  logic [`ROP_ADDR_BITS-1:0] mem_addr,
    output int mem_errors, rsp_errors, ctl_errors,
    output logic drained
);

    localparam int NUM_SLOTS = 2 * `ROP_NUM_LANES;

    logic [31:0] shadow [logic [`ROP_ADDR_BITS-1:0]];  // Expected framebuffer words.
    mem_op_e exp_op [$];
    logic [`ROP_ADDR_BITS-1:0] exp_addr [$];
    logic [31:0] exp_wdata [$];
    logic [3:0] exp_be [$];
    logic [`ROP_NUM_LANES-1:0] exp_mask [$];
    logic [`ROP_TAG_BITS-1:0] exp_tag [$];
    logic [NUM_SLOTS-1:0][31:0] exp_rdata [$];
    logic req_ack_q, mem_req_q, rsp_req_q;
    logic seen_req = 1'b0;

    function automatic logic [31:0] fill_word(input logic [`ROP_ADDR_BITS-1:0] addr);
        return {addr, 2'b11} ^ 32'h6a5c_3e91;
    endfunction

    // Slots of the request on the port, in issue order, and its response.
    function automatic void predict();
        logic [NUM_SLOTS-1:0][31:0] rdata;
        logic [`ROP_NUM_LANES-1:0] lanes;
        logic [31:0] byte_addr, word, old, keep;
        logic [`ROP_ADDR_BITS-1:0] addr;
        logic [7:0] swm;
        logic [3:0] be;
        logic read, on;
        int i;
        rdata = '0;
        lanes = '0;
        read = (req_op == MEM_READ);
        for (int s = 0; s < NUM_SLOTS; s++) begin
            i = s % `ROP_NUM_LANES;
            if (s < `ROP_NUM_LANES) begin
                byte_addr = zbuf_addr + 32'(req_pos_y[i]) * zbuf_pitch + 32'(req_pos_x[i]) * 4;
                swm = req_backface[i] ? stencil_back_writemask : stencil_front_writemask;
                on = (depth_enable && (read || depth_writemask)) || (stencil_enable
                     && (read || |stencil_front_writemask || |stencil_back_writemask));
                word = {req_stencil[i], req_depth[i]};
                be = {|swm, {3{depth_writemask}}};
            end else begin
                byte_addr = cbuf_addr + 32'(req_pos_y[i]) * cbuf_pitch + 32'(req_pos_x[i]) * 4;
                on = (read ? blend_enable : |cbuf_writemask) && (read || req_ds_pass[i]);
                word = req_color[i];
                be = cbuf_writemask;
            end
            if (req_lane_mask[i] && on) begin
                addr = byte_addr[31:2];
                lanes[i] = 1'b1;
                old = shadow.exists(addr) ? shadow[addr] : fill_word(addr);
                keep = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
                exp_op.push_back(req_op);
                exp_addr.push_back(addr);
                exp_wdata.push_back(word);
                exp_be.push_back(be);
                if (read) begin
                    rdata[s] = old;
                end else begin
                    shadow[addr] = (old & ~keep) | (word & keep);
                end
            end
        end
        exp_mask.push_back(lanes);
        exp_tag.push_back(req_tag);
        exp_rdata.push_back(rdata);
    endfunction

    task automatic compare_mem_slot();
        mem_op_e e_op;
        logic [`ROP_ADDR_BITS-1:0] e_addr;
        logic [31:0] e_wdata;
        logic [3:0] e_be;
        if (exp_op.size() == 0) begin
            $display("FAIL %0t: memory access to %h with no slot expected", $time, mem_addr);
            mem_errors++;
            return;
        end
        e_op = exp_op.pop_front();
        e_addr = exp_addr.pop_front();
        e_wdata = exp_wdata.pop_front();
        e_be = exp_be.pop_front();
        if (mem_op !== e_op || mem_addr !== e_addr
            || (e_op == MEM_WRITE && (mem_wdata !== e_wdata || mem_byteen !== e_be))) begin
            $display("FAIL %0t: memory slot op %0d addr %h data %h be %h, expected %0d %h %h %h",
                     $time, mem_op, mem_addr, mem_wdata, mem_byteen, e_op, e_addr, e_wdata, e_be);
            mem_errors++;
        end
    endtask

    task automatic compare_response();
        logic [NUM_SLOTS-1:0][31:0] got;
        for (int i = 0; i < `ROP_NUM_LANES; i++) begin
            got[i] = {rsp_stencil[i], rsp_depth[i]};
            got[`ROP_NUM_LANES + i] = rsp_color[i];
        end
        if (exp_mask.size() == 0) begin
            $display("FAIL %0t: response tag %0d with no request pending", $time, rsp_tag);
            rsp_errors++;
            return;
        end
        if (rsp_mask !== exp_mask[0] || rsp_tag !== exp_tag[0] || got !== exp_rdata[0]) begin
            $display("FAIL %0t: response mask %b tag %0d data %h, expected %b %0d %h",
                     $time, rsp_mask, rsp_tag, got, exp_mask[0], exp_tag[0], exp_rdata[0]);
            rsp_errors++;
        end
        exp_mask.delete(0);
        exp_tag.delete(0);
        exp_rdata.delete(0);
    endtask

    always @(posedge clk) begin
        if (!arst_n) begin
            req_ack_q <= 1'b0;
            mem_req_q <= 1'b0;
            rsp_req_q <= 1'b0;
            mem_errors = 0;
            rsp_errors = 0;
            ctl_errors = 0;
        end else begin
            req_ack_q <= req_ack;
            mem_req_q <= mem_req;
            rsp_req_q <= rsp_req;
            if (!seen_req && (req_ack || mem_req || rsp_req)) begin
                $display("FAIL %0t: handshake output raised before any request", $time);
                ctl_errors++;
            end
            if (req) begin
                seen_req = 1'b1;
            end
            if (req_ack && !req_ack_q) begin
                predict();  // Source still holds the fields.
            end
            if (mem_req && !mem_req_q) begin
                compare_mem_slot();
            end
            if (rsp_req && !rsp_req_q) begin
                compare_response();
            end
            drained = (exp_op.size() == 0) && (exp_mask.size() == 0);
        end
    end

endmodule

/* rop_mem_tb.sv */
`timescale 1ns/1ps
`include "rop_params.svh"

module rop_mem_tb
    import rop_pkg::*;
();

    localparam int NUM_GROUPS = 40;
    localparam int GROUP_REQS = 4;
    localparam int TIMEOUT_NS = (NUM_GROUPS * GROUP_REQS * (8 * 14 + 20) + 1000) * 10;

    logic clk, arst_n, req, req_ack, mem_req, mem_ack, rsp_req, rsp_ack, drained;
    logic depth_enable, depth_writemask, stencil_enable, blend_enable;
    logic [31:0] zbuf_addr, zbuf_pitch, cbuf_addr, cbuf_pitch, mem_wdata, mem_rdata;
    logic [7:0] stencil_front_writemask, stencil_back_writemask;
    logic [3:0] cbuf_writemask, mem_byteen;
    mem_op_e req_op, mem_op;
    logic [`ROP_TAG_BITS-1:0] req_tag, rsp_tag;
    logic [`ROP_NUM_LANES-1:0] req_lane_mask, req_ds_pass, req_backface, rsp_mask;
    logic [`ROP_NUM_LANES-1:0][`ROP_DIM_BITS-1:0] req_pos_x, req_pos_y;
    logic [`ROP_NUM_LANES-1:0][31:0] req_color, rsp_color;
    logic [`ROP_NUM_LANES-1:0][`ROP_DEPTH_BITS-1:0] req_depth, rsp_depth;
    logic [`ROP_NUM_LANES-1:0][`ROP_STENCIL_BITS-1:0] req_stencil, rsp_stencil;
    logic [`ROP_ADDR_BITS-1:0] mem_addr;
    logic [31:0] mem_words [logic [`ROP_ADDR_BITS-1:0]];  // Sparse memory.
    logic [31:0] rng_state = 32'h6667;
    int mem_errors, rsp_errors, ctl_errors;
    int sent_count = 0;
    int rsp_count = 0;
    int left_errors = 0;

    rop_mem dut_i (.*);
    rop_mem_checker chk_i (.*);

    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic logic [31:0] fill_word(input logic [`ROP_ADDR_BITS-1:0] addr);
        return {addr, 2'b11} ^ 32'h6a5c_3e91;  // Unwritten words.
    endfunction

    task automatic random_delay();
        logic [31:0] rnd;
        rnd = next_random();
        repeat (rnd % 6) @(negedge clk);
    endtask

    task automatic pick_config(input logic wide);
        logic [31:0] rnd;
        rnd = next_random();
        {blend_enable, stencil_enable, depth_writemask, depth_enable} = rnd[3:0];
        stencil_front_writemask = (rnd[5:4] == 2'b00) ? 8'h00 : rnd[15:8];
        stencil_back_writemask = (rnd[7:6] == 2'b00) ? 8'h00 : rnd[23:16];
        cbuf_writemask = rnd[27:24];
        zbuf_addr = next_random();
        cbuf_addr = next_random();
        rnd = next_random();
        zbuf_pitch = {20'd0, rnd[9:0], 2'b00};
        cbuf_pitch = {20'd0, rnd[25:16], 2'b00};
        for (int i = 0; i < `ROP_NUM_LANES; i++) begin
            rnd = next_random();
            req_pos_x[i] = wide ? rnd[10:0] : {8'd0, rnd[2:0]};  // Small area so lanes collide.
            req_pos_y[i] = wide ? rnd[26:16] : {8'd0, rnd[18:16]};
        end
    endtask

    task automatic send_request(input mem_op_e op);
        logic [31:0] rnd;
        @(negedge clk);
        rnd = next_random();
        req_op = op;
        req_tag = sent_count[`ROP_TAG_BITS-1:0];
        req_lane_mask = rnd[3:0];
        req_ds_pass = rnd[7:4] | rnd[11:8];  // Mostly passing.
        req_backface = rnd[15:12];
        for (int i = 0; i < `ROP_NUM_LANES; i++) begin
            req_color[i] = next_random();
            rnd = next_random();
            req_depth[i] = rnd[23:0];
            req_stencil[i] = rnd[31:24];
        end
        sent_count++;
        req = 1'b1;
        while (!req_ack) @(negedge clk);
        req = 1'b0;
        while (req_ack) @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        req = 1'b0;
        req_op = MEM_READ;
        req_tag = '0;
        req_lane_mask = '0;
        req_ds_pass = '0;
        req_backface = '0;
        req_color = '0;
        req_depth = '0;
        req_stencil = '0;
        pick_config(1'b0);
        arst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        repeat (10) @(negedge clk);  // Idle window after reset.
        for (int g = 0; g < NUM_GROUPS; g++) begin
            pick_config(g[0]);
            for (int k = 0; k < GROUP_REQS; k++) begin
                send_request(k[0] ? MEM_READ : MEM_WRITE);  // Read back what was written.
            end
            while (rsp_count != sent_count) @(negedge clk);
        end
        repeat (10) @(negedge clk);
        if (!drained) begin
            $display("Error: expected memory slots or responses were never seen");
            left_errors++;
        end
        if (mem_errors + rsp_errors + ctl_errors + left_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $display("Errors: memory %0d, response %0d, handshake %0d, leftover %0d",
                 mem_errors, rsp_errors, ctl_errors, left_errors);
        $finish;
    end

    initial begin
        logic [31:0] word;
        mem_ack = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge clk);
            if (mem_req) begin
                random_delay();
                word = mem_words.exists(mem_addr) ? mem_words[mem_addr] : fill_word(mem_addr);
                if (mem_op == MEM_WRITE) begin
                    for (int b = 0; b < 4; b++) begin
                        if (mem_byteen[b]) begin
                            word[8*b +: 8] = mem_wdata[8*b +: 8];
                        end
                    end
                    mem_words[mem_addr] = word;
                end else begin
                    mem_rdata = word;
                end
                mem_ack = 1'b1;
                while (mem_req) @(negedge clk);
                random_delay();
                mem_ack = 1'b0;
            end
        end
    end

    initial begin
        rsp_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (rsp_req) begin
                random_delay();
                rsp_ack = 1'b1;
                rsp_count++;
                while (rsp_req) @(negedge clk);
                random_delay();
                rsp_ack = 1'b0;
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Error: timeout after %0d ns, a handshake never completed", TIMEOUT_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* sim.f */
+incdir+.
rop_pkg.sv
rop_ds_addr.sv
rop_color_addr.sv
rop_mem_seq.sv
rop_mem.sv
rop_mem_checker.sv
rop_mem_tb.sv

/* Bender.yml */
package:
  name: rop_mem

export_include_dirs:
  - .

sources:
  - rop_pkg.sv
  - rop_ds_addr.sv
  - rop_color_addr.sv
  - rop_mem_seq.sv
  - rop_mem.sv
  - target: simulation
    files:
      - rop_mem_checker.sv
      - rop_mem_tb.sv
